/* rtl/w5500_cfg.svh */
`ifndef W5500_CFG_SVH
`define W5500_CFG_SVH

// control byte block selects, already shifted into bits 7:3
`define W5500_BSB_COMMON    8'h00
`define W5500_BSB_S0_REG    8'h08
`define W5500_BSB_S0_RXBUF  8'h18
`define W5500_RWB_WRITE     8'h04

// common and socket register offsets
`define W5500_GAR        16'h0001
`define W5500_SUBR       16'h0005
`define W5500_SHAR       16'h0009
`define W5500_SIPR       16'h000f
`define W5500_SN_MR      16'h0000
`define W5500_SN_CR      16'h0001
`define W5500_SN_PORT    16'h0004
`define W5500_SN_RX_RSR  16'h0026
`define W5500_SN_RX_RD   16'h0028

`define W5500_CMD_OPEN    8'h01
`define W5500_CMD_LISTEN  8'h02
`define W5500_CMD_RECV    8'h40
`define W5500_MR_TCP      8'h01

`define NET_GATEWAY  32'hc0a8_6401    // 192.168.100.1
`define NET_MASK     32'hffff_ff00
`define NET_MAC      48'h0c29_ab7c_0001
`define NET_IP       32'hc0a8_6410    // 192.168.100.16
`define NET_PORT     16'h1388         // 5000

// short values for simulation, chip needs ms range
`define RST_LOW_CYC     50
`define RST_WAIT_CYC    200
`define POLL_GAP_CYC    64
`define SPI_HALF_CYC    2
`define REC_BYTES       17
`define SPI_MAX_WBYTES  6

`endif

/* rtl/w5500_pkg.sv */
`include "w5500_cfg.svh"

package w5500_pkg;

	typedef logic [15:0] spi_addr_t;
	typedef logic [4:0]  spi_len_t;                         // data bytes per frame
	typedef logic [`SPI_MAX_WBYTES*8-1:0] spi_wdata_t;      // first byte on top

	// one record as sent by the host, big endian words
	typedef struct packed {
		logic [15:0] back_len;
		logic [15:0] back_wid;
		logic [15:0] front_len;
		logic [15:0] front_wid;
		logic [15:0] point_x;
		logic [15:0] point_y;
		logic [15:0] width;
		logic [15:0] height;
		logic [7:0]  save;
	} rec_fields_t;

	typedef union packed {
		rec_fields_t fields;
		logic [`REC_BYTES-1:0][7:0] bytes;   // byte 0 of the stream sits on top
	} rec_u;

endpackage

/* rtl/w5500_spi_if.sv */
`timescale 1ns/1ps

interface w5500_spi_if;

	logic                   req;
	logic                   write;
	w5500_pkg::spi_addr_t   addr;
	logic [7:0]             bsb;
	w5500_pkg::spi_len_t    len;
	w5500_pkg::spi_wdata_t  wdata;
	logic [7:0]             rbyte;
	logic                   rbyte_valid;   // one pulse per data byte read
	logic                   done;          // frame finished, cs is high again

	modport requester (output req, write, addr, bsb, len, wdata,
		input rbyte, rbyte_valid, done);

	modport engine (input req, write, addr, bsb, len, wdata,
		output rbyte, rbyte_valid, done);

endinterface

/* rtl/w5500_spi_master.sv */
`timescale 1ns/1ps
`include "w5500_cfg.svh"

module w5500_spi_master (
	input  logic        clk,
	input  logic        rst_n,
	w5500_spi_if.engine cmd,
	output logic        sck,
	output logic        mosi,
	input  logic        miso,
	output logic        scs_n
);

	localparam int HDR_BITS = 24;   // address plus control byte
	localparam int SR_BITS  = HDR_BITS + $bits(w5500_pkg::spi_wdata_t);

	typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_FINISH} state_t;

	state_t                 state;
	logic [SR_BITS-1:0]     tx_sr;
	logic [6:0]             rx_sr;
	logic [7:0]             bit_cnt;
	logic [7:0]             bit_total;
	logic [7:0]             bit_next;
	logic [7:0]             div_cnt;
	logic                   rd_frame;
	logic                   tick;
	logic [7:0]             ctrl_byte;
	w5500_pkg::spi_wdata_t  wdata_sel;

	assign mosi      = tx_sr[SR_BITS-1];
	assign bit_next  = bit_cnt + 8'd1;
	assign tick      = (state == S_SHIFT) && (div_cnt == 8'(`SPI_HALF_CYC - 1));
	assign ctrl_byte = cmd.bsb | (cmd.write ? `W5500_RWB_WRITE : 8'h00);
	assign wdata_sel = cmd.write ? cmd.wdata : w5500_pkg::spi_wdata_t'(0);  // mosi low on reads

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state           <= S_IDLE;
			sck             <= 1'b0;
			scs_n           <= 1'b1;
			tx_sr           <= '0;
			bit_cnt         <= '0;
			bit_total       <= '0;
			div_cnt         <= '0;
			rd_frame        <= 1'b0;
			cmd.rbyte_valid <= 1'b0;
			cmd.done        <= 1'b0;
		end
		else
		begin
			cmd.rbyte_valid <= 1'b0;
			cmd.done        <= 1'b0;
			case (state)
				S_IDLE:
				begin
					// req stays high in the done cycle so skip it
					if (cmd.req && !cmd.done)
					begin
						tx_sr     <= {cmd.addr, ctrl_byte, wdata_sel};
						bit_total <= (8'd3 + 8'(cmd.len)) << 3;
						rd_frame  <= !cmd.write;
						bit_cnt   <= '0;
						div_cnt   <= '0;
						scs_n     <= 1'b0;
						state     <= S_SHIFT;
					end
				end
				S_SHIFT:
				begin
					if (tick)
					begin
						div_cnt <= '0;
						sck     <= ~sck;
						if (!sck)
						begin
							bit_cnt <= bit_next;    // rising edge samples miso
							if (rd_frame && bit_next > 8'd24 && bit_next[2:0] == 3'd0)
								cmd.rbyte_valid <= 1'b1;
						end
						else
						begin
							tx_sr <= tx_sr << 1;
							if (bit_cnt == bit_total)
							begin
								scs_n <= 1'b1;
								state <= S_FINISH;
							end
						end
					end
					else
						div_cnt <= div_cnt + 8'd1;
				end
				default:
				begin
					cmd.done <= 1'b1;
					state    <= S_IDLE;
				end
			endcase
		end
	end

	// read data path
	always_ff @(posedge clk)
	begin
		if (tick && !sck)
		begin
			rx_sr     <= {rx_sr[5:0], miso};
			cmd.rbyte <= {rx_sr, miso};
		end
	end

endmodule

/* rtl/w5500_setup_seq.sv */
`timescale 1ns/1ps
`include "w5500_cfg.svh"

module w5500_setup_seq (
	input  logic           clk,
	input  logic           rst_n,
	w5500_spi_if.requester cmd,
	output logic           w5500_rst_n,
	output logic           setup_done
);

	localparam logic [2:0] LAST_STEP = 3'd7;

	typedef enum logic [2:0] {S_START, S_LOW, S_WAIT, S_WRITE, S_DONE} state_t;

	state_t      state;
	logic [23:0] cnt;     // wide enough for real ms delays
	logic [2:0]  step;

	assign cmd.write = 1'b1;

	// one write frame per table entry
	always_comb
	begin
		cmd.bsb = `W5500_BSB_S0_REG;
		cmd.len = 5'd1;
		case (step)
			3'd0:
			begin
				cmd.addr  = `W5500_GAR;
				cmd.bsb   = `W5500_BSB_COMMON;
				cmd.len   = 5'd4;
				cmd.wdata = {`NET_GATEWAY, 16'h0000};
			end
			3'd1:
			begin
				cmd.addr  = `W5500_SUBR;
				cmd.bsb   = `W5500_BSB_COMMON;
				cmd.len   = 5'd4;
				cmd.wdata = {`NET_MASK, 16'h0000};
			end
			3'd2:
			begin
				cmd.addr  = `W5500_SHAR;
				cmd.bsb   = `W5500_BSB_COMMON;
				cmd.len   = 5'd6;
				cmd.wdata = `NET_MAC;
			end
			3'd3:
			begin
				cmd.addr  = `W5500_SIPR;
				cmd.bsb   = `W5500_BSB_COMMON;
				cmd.len   = 5'd4;
				cmd.wdata = {`NET_IP, 16'h0000};
			end
			3'd4:
			begin
				cmd.addr  = `W5500_SN_MR;
				cmd.wdata = {`W5500_MR_TCP, 40'h0};
			end
			3'd5:
			begin
				cmd.addr  = `W5500_SN_PORT;
				cmd.len   = 5'd2;
				cmd.wdata = {`NET_PORT, 32'h0};
			end
			3'd6:
			begin
				cmd.addr  = `W5500_SN_CR;
				cmd.wdata = {`W5500_CMD_OPEN, 40'h0};
			end
			default:
			begin
				cmd.addr  = `W5500_SN_CR;
				cmd.wdata = {`W5500_CMD_LISTEN, 40'h0};
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state       <= S_START;
			cnt         <= '0;
			step        <= '0;
			cmd.req     <= 1'b0;
			w5500_rst_n <= 1'b1;
			setup_done  <= 1'b0;
		end
		else
		begin
			case (state)
				S_START:
				begin
					w5500_rst_n <= 1'b0;
					cnt         <= '0;
					state       <= S_LOW;
				end
				S_LOW:
				begin
					if (cnt == 24'(`RST_LOW_CYC - 1))
					begin
						w5500_rst_n <= 1'b1;
						cnt         <= '0;
						state       <= S_WAIT;
					end
					else
						cnt <= cnt + 24'd1;
				end
				S_WAIT:
				begin
					if (cnt == 24'(`RST_WAIT_CYC - 1))   // chip PLL settles here
						state <= S_WRITE;
					else
						cnt <= cnt + 24'd1;
				end
				S_WRITE:
				begin
					cmd.req <= !cmd.done;
					if (cmd.done)
					begin
						if (step == LAST_STEP)
						begin
							setup_done <= 1'b1;
							state      <= S_DONE;
						end
						else
							step <= step + 3'd1;
					end
				end
				default:
					cmd.req <= 1'b0;
			endcase
		end
	end

endmodule

/* rtl/w5500_rx_engine.sv */
`timescale 1ns/1ps
`include "w5500_cfg.svh"

module w5500_rx_engine (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    enable,
	w5500_spi_if.requester          cmd,
	output w5500_pkg::rec_fields_t  rec,
	output logic                    record_valid
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_POLL,
		S_GAP,
		S_RD_PTR,
		S_BURST,
		S_WR_PTR,
		S_RECV
	} state_t;

	state_t                state;
	logic [15:0]           gap_cnt;
	logic [15:0]           rd_word;    // two byte reads land msb first
	logic [15:0]           rd_ptr;
	logic [15:0]           ptr_next;
	logic                  frame_state;
	w5500_pkg::rec_u       rec_buf;

	assign ptr_next    = rd_ptr + 16'(`REC_BYTES);   // wraps like the chip pointer
	assign frame_state = (state != S_IDLE) && (state != S_GAP);

	always_comb
	begin
		cmd.write = 1'b0;
		cmd.bsb   = `W5500_BSB_S0_REG;
		cmd.len   = 5'd2;
		cmd.wdata = '0;
		case (state)
			S_RD_PTR: cmd.addr = `W5500_SN_RX_RD;
			S_BURST:
			begin
				cmd.addr = rd_ptr;
				cmd.bsb  = `W5500_BSB_S0_RXBUF;
				cmd.len  = 5'(`REC_BYTES);
			end
			S_WR_PTR:
			begin
				cmd.addr  = `W5500_SN_RX_RD;
				cmd.write = 1'b1;
				cmd.wdata = {ptr_next, 32'h0};
			end
			S_RECV:
			begin
				cmd.addr  = `W5500_SN_CR;
				cmd.write = 1'b1;
				cmd.len   = 5'd1;
				cmd.wdata = {`W5500_CMD_RECV, 40'h0};
			end
			default: cmd.addr = `W5500_SN_RX_RSR;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state        <= S_IDLE;
			gap_cnt      <= '0;
			cmd.req      <= 1'b0;
			record_valid <= 1'b0;
		end
		else
		begin
			record_valid <= 1'b0;
			cmd.req      <= frame_state && !cmd.done;   // low for a cycle between frames
			case (state)
				S_IDLE:
					if (enable)
						state <= S_POLL;
				S_POLL:
				begin
					gap_cnt <= '0;
					if (cmd.done)
						state <= (rd_word < 16'(`REC_BYTES)) ? S_GAP : S_RD_PTR;
				end
				S_GAP:
				begin
					if (gap_cnt == 16'(`POLL_GAP_CYC - 1))
						state <= S_POLL;
					else
						gap_cnt <= gap_cnt + 16'd1;
				end
				S_RD_PTR: if (cmd.done) state <= S_BURST;
				S_BURST:  if (cmd.done) state <= S_WR_PTR;
				S_WR_PTR: if (cmd.done) state <= S_RECV;
				default:
				begin
					if (cmd.done)
					begin
						record_valid <= 1'b1;
						state        <= S_POLL;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd.rbyte_valid)
		begin
			rd_word <= {rd_word[7:0], cmd.rbyte};
			if (state == S_BURST)
				rec_buf.bytes <= {rec_buf.bytes[`REC_BYTES-2:0], cmd.rbyte};
		end
		if (state == S_RD_PTR && cmd.done)
			rd_ptr <= rd_word;
		if (state == S_RECV && cmd.done)
			rec <= rec_buf.fields;   // same word seen as fields
	end

endmodule

/* rtl/w5500_ctrl_top.sv */
`timescale 1ns/1ps

module w5500_ctrl_top (
	input  logic        clk,
	input  logic        rst_n,
	output logic        sck,
	output logic        mosi,
	input  logic        miso,
	output logic        scs_n,
	output logic        w5500_rst_n,
	output logic [15:0] back_len,
	output logic [15:0] back_wid,
	output logic [15:0] front_len,
	output logic [15:0] front_wid,
	output logic [15:0] point_x,
	output logic [15:0] point_y,
	output logic [15:0] width,
	output logic [15:0] height,
	output logic [7:0]  save,
	output logic        record_valid
);

	w5500_spi_if eng_if ();
	w5500_spi_if setup_if ();
	w5500_spi_if rx_if ();

	logic                    setup_done;
	w5500_pkg::rec_fields_t  rec;

	// setup owns the engine until its table is through
	assign eng_if.req   = setup_done ? rx_if.req   : setup_if.req;
	assign eng_if.write = setup_done ? rx_if.write : setup_if.write;
	assign eng_if.addr  = setup_done ? rx_if.addr  : setup_if.addr;
	assign eng_if.bsb   = setup_done ? rx_if.bsb   : setup_if.bsb;
	assign eng_if.len   = setup_done ? rx_if.len   : setup_if.len;
	assign eng_if.wdata = setup_done ? rx_if.wdata : setup_if.wdata;

	assign setup_if.rbyte       = eng_if.rbyte;
	assign setup_if.rbyte_valid = eng_if.rbyte_valid;
	assign setup_if.done        = eng_if.done;
	assign rx_if.rbyte          = eng_if.rbyte;
	assign rx_if.rbyte_valid    = eng_if.rbyte_valid;
	assign rx_if.done           = eng_if.done;

	w5500_setup_seq u_setup (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd         (setup_if.requester),
		.w5500_rst_n (w5500_rst_n),
		.setup_done  (setup_done)
	);

	w5500_rx_engine u_rx (
		.clk          (clk),
		.rst_n        (rst_n),
		.enable       (setup_done),
		.cmd          (rx_if.requester),
		.rec          (rec),
		.record_valid (record_valid)
	);

	w5500_spi_master u_spi (
		.clk   (clk),
		.rst_n (rst_n),
		.cmd   (eng_if.engine),
		.sck   (sck),
		.mosi  (mosi),
		.miso  (miso),
		.scs_n (scs_n)
	);

	assign back_len  = rec.back_len;
	assign back_wid  = rec.back_wid;
	assign front_len = rec.front_len;
	assign front_wid = rec.front_wid;
	assign point_x   = rec.point_x;
	assign point_y   = rec.point_y;
	assign width     = rec.width;
	assign height    = rec.height;
	assign save      = rec.save;

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int RST_CYCLES = 16;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 10 ns period
	end

	// release on a falling edge, like the other inputs
	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* testbench/w5500_slave_model.sv */
`timescale 1ns/1ps
`include "w5500_cfg.svh"

module w5500_slave_model (
	input  logic clk,
	input  logic sck,
	input  logic mosi,
	input  logic scs_n,
	output logic miso
);

	localparam int MAX_FRAMES = 64;
	localparam int MAX_VALS   = 16;

	// values to serve, filled in by the testbench top
	logic [15:0]  rsr_vals [MAX_VALS];
	int           rsr_cnt;
	logic [15:0]  rec_ptr [MAX_VALS];
	logic [135:0] rec_data [MAX_VALS];   // byte 0 on top
	int           rec_cnt;

	// one entry per finished frame
	logic         frm_write [MAX_FRAMES];
	logic [15:0]  frm_addr [MAX_FRAMES];
	logic [7:0]   frm_bsb [MAX_FRAMES];
	int           frm_len [MAX_FRAMES];
	logic [47:0]  frm_data [MAX_FRAMES];
	int           frm_cnt = 0;

	int           bit_cnt = 0;
	int           rsr_idx = 0;
	int           rec_idx = 0;
	logic [23:0]  hdr;
	logic [7:0]   byte_sr;
	logic [47:0]  wr_bytes;
	logic [135:0] resp;   // read answer, shifted out msb first

	initial
	begin
		miso = 1'b0;
	end

	// pick the answer once the control byte is in
	task automatic serve_read(input logic [15:0] addr, input logic [7:0] bsb);
		resp = '0;
		if (bsb == `W5500_BSB_S0_RXBUF)
			resp = (rec_idx < rec_cnt) ? rec_data[rec_idx] : '0;
		else if (bsb == `W5500_BSB_S0_REG && addr == `W5500_SN_RX_RSR)
		begin
			resp[135:120] = (rsr_idx < rsr_cnt) ? rsr_vals[rsr_idx] : 16'h0000;
			rsr_idx++;
		end
		else if (bsb == `W5500_BSB_S0_REG && addr == `W5500_SN_RX_RD)
			resp[135:120] = (rec_idx < rec_cnt) ? rec_ptr[rec_idx] : 16'h0000;
	endtask

	always @(negedge scs_n)
	begin
		bit_cnt  = 0;
		wr_bytes = '0;
		resp     = '0;
	end

	always @(posedge sck)
	begin
		int k;
		if (!scs_n)
		begin
			if (bit_cnt < 24)
				hdr = {hdr[22:0], mosi};
			else
				byte_sr = {byte_sr[6:0], mosi};
			bit_cnt++;
			if (bit_cnt == 24 && !hdr[2])
				serve_read(hdr[23:8], hdr[7:0] & 8'hf8);
			else if (bit_cnt >= 32 && bit_cnt % 8 == 0 && hdr[2])
			begin
				k = (bit_cnt - 32) / 8;
				if (k < 6)
					wr_bytes[47 - 8 * k -: 8] = byte_sr;
			end
		end
	end

	// mode 0, next bit goes out after the falling sck edge
	always @(negedge sck)
	begin
		if (!scs_n && bit_cnt >= 24)
		begin
			@(negedge clk);
			miso = resp[135];
			resp = resp << 1;
		end
	end

	always @(posedge scs_n)
	begin
		if (bit_cnt >= 24)   // skips the reset edge
		begin
			if (frm_cnt < MAX_FRAMES)
			begin
				frm_write[frm_cnt] = hdr[2];
				frm_addr[frm_cnt]  = hdr[23:8];
				frm_bsb[frm_cnt]   = hdr[7:0] & 8'hf8;
				frm_len[frm_cnt]   = (bit_cnt - 24) / 8;
				frm_data[frm_cnt]  = wr_bytes;
				frm_cnt++;
			end
			if (!hdr[2] && (hdr[7:0] & 8'hf8) == `W5500_BSB_S0_RXBUF)
				rec_idx++;   // next record after its burst
			bit_cnt = 0;
		end
		miso = 1'b0;
	end

endmodule

/* testbench/tb_w5500_top.sv */
`timescale 1ns/1ps
`include "w5500_cfg.svh"

module tb_w5500_top;

	localparam string TRACE_PATH = "testbench/w5500_rx_trace.txt";
	localparam int    MAX_VALS   = 16;
	localparam int    CLK_NS     = 10;
	localparam longint FRAME_NS  = (3 + `REC_BYTES) * 16 * `SPI_HALF_CYC * CLK_NS;

	logic        clk;
	logic        rst_n;
	logic        sck;
	logic        mosi;
	logic        miso;
	logic        scs_n;
	logic        w5500_rst_n;
	logic [15:0] back_len;
	logic [15:0] back_wid;
	logic [15:0] front_len;
	logic [15:0] front_wid;
	logic [15:0] point_x;
	logic [15:0] point_y;
	logic [15:0] width;
	logic [15:0] height;
	logic [7:0]  save;
	logic        record_valid;

	// expected setup writes and served records from the trace
	logic [15:0]  exp_w_addr [MAX_VALS];
	logic [7:0]   exp_w_bsb [MAX_VALS];
	int           exp_w_len [MAX_VALS];
	logic [47:0]  exp_w_data [MAX_VALS];
	logic [15:0]  exp_rsr [MAX_VALS];
	logic [15:0]  exp_ptr [MAX_VALS];
	logic [135:0] exp_rec [MAX_VALS];
	int           w_cnt = 0;
	int           rsr_cnt = 0;
	int           rec_cnt = 0;
	logic         trace_ok = 1'b0;

	int           n_checks = 0;
	int           n_errors = 0;
	int           rec_seen = 0;
	int           frames_before;
	int           low_cycles;
	logic         valid_prev = 1'b0;
	logic         log_short = 1'b0;
	longint       limit_ns = 0;

	tb_clk_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	w5500_ctrl_top UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.sck          (sck),
		.mosi         (mosi),
		.miso         (miso),
		.scs_n        (scs_n),
		.w5500_rst_n  (w5500_rst_n),
		.back_len     (back_len),
		.back_wid     (back_wid),
		.front_len    (front_len),
		.front_wid    (front_wid),
		.point_x      (point_x),
		.point_y      (point_y),
		.width        (width),
		.height       (height),
		.save         (save),
		.record_valid (record_valid)
	);

	w5500_slave_model u_slave (
		.clk   (clk),
		.sck   (sck),
		.mosi  (mosi),
		.scs_n (scs_n),
		.miso  (miso)
	);

	task automatic check_value(input string name, input logic [135:0] exp,
		input logic [135:0] act);
		n_checks++;
		if (exp !== act)
		begin
			$display("ERROR at %0t ns: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
			n_errors++;
		end
	endtask

	task automatic finish_run();
		$display("Summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	task automatic load_trace();
		int           fd;
		int           n;
		string        line;
		logic [7:0]   kind;
		logic [15:0]  a16;
		logic [7:0]   b8;
		int           len;
		logic [47:0]  d48;
		logic [135:0] d136;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1)
			begin
				kind = line.getc(0);
				if (kind == "W" && w_cnt < MAX_VALS &&
					$sscanf(line, "%c %h %h %d %h", kind, a16, b8, len, d48) == 5)
				begin
					exp_w_addr[w_cnt] = a16;
					exp_w_bsb[w_cnt]  = b8;
					exp_w_len[w_cnt]  = len;
					exp_w_data[w_cnt] = d48;
					w_cnt++;
				end
				else if (kind == "S" && rsr_cnt < MAX_VALS &&
					$sscanf(line, "%c %h", kind, a16) == 2)
				begin
					exp_rsr[rsr_cnt] = a16;
					u_slave.rsr_vals[rsr_cnt] = a16;
					rsr_cnt++;
				end
				else if (kind == "R" && rec_cnt < MAX_VALS &&
					$sscanf(line, "%c %h %h", kind, a16, d136) == 3)
				begin
					exp_ptr[rec_cnt] = a16;
					exp_rec[rec_cnt] = d136;
					u_slave.rec_ptr[rec_cnt]  = a16;
					u_slave.rec_data[rec_cnt] = d136;
					rec_cnt++;
				end
			end
		end
		$fclose(fd);
		u_slave.rsr_cnt = rsr_cnt;
		u_slave.rec_cnt = rec_cnt;
		trace_ok = (w_cnt > 0) && (rec_cnt > 0);
	endtask

	task automatic expect_frame(input int f, input logic wr, input logic [15:0] addr,
		input logic [7:0] bsb, input int len, input logic [47:0] data);
		if (f >= u_slave.frm_cnt)
		begin
			if (!log_short)
			begin
				$display("Frame log ends before frame %0d, the DUT sent too few frames", f);
				n_errors++;
			end
			log_short = 1'b1;
		end
		else
		begin
			check_value($sformatf("frame %0d write", f), wr, u_slave.frm_write[f]);
			check_value($sformatf("frame %0d addr", f), addr, u_slave.frm_addr[f]);
			check_value($sformatf("frame %0d bsb", f), bsb, u_slave.frm_bsb[f]);
			check_value($sformatf("frame %0d len", f), len, u_slave.frm_len[f]);
			check_value($sformatf("frame %0d data", f), data, u_slave.frm_data[f]);
		end
	endtask

	// replays the poll rule against the logged frames
	task automatic verify_frames();
		int          f;
		int          ri;
		int          r;
		logic [15:0] served;
		logic [15:0] ptr_wr;
		for (f = 0; f < w_cnt; f++)
			expect_frame(f, 1'b1, exp_w_addr[f], exp_w_bsb[f], exp_w_len[f], exp_w_data[f]);
		ri = 0;
		r  = 0;
		while (r < rec_cnt && !log_short)
		begin
			expect_frame(f, 1'b0, `W5500_SN_RX_RSR, `W5500_BSB_S0_REG, 2, 48'h0);
			served = (ri < rsr_cnt) ? exp_rsr[ri] : 16'h0000;
			ri++;
			f++;
			if (served >= `REC_BYTES)
			begin
				ptr_wr = exp_ptr[r] + 16'd17;   // wraps at 64k
				expect_frame(f, 1'b0, `W5500_SN_RX_RD, `W5500_BSB_S0_REG, 2, 48'h0);
				expect_frame(f + 1, 1'b0, exp_ptr[r], `W5500_BSB_S0_RXBUF, 17, 48'h0);
				expect_frame(f + 2, 1'b1, `W5500_SN_RX_RD, `W5500_BSB_S0_REG, 2,
					{ptr_wr, 32'h0});
				expect_frame(f + 3, 1'b1, `W5500_SN_CR, `W5500_BSB_S0_REG, 1,
					{8'h40, 40'h0});
				f = f + 4;
				r++;
			end
		end
	endtask

	task automatic check_record();
		logic [135:0] e;
		if (rec_seen >= rec_cnt)
		begin
			$display("Extra record_valid pulse at %0t ns with no record served", $time);
			n_errors++;
		end
		else
		begin
			e = exp_rec[rec_seen];   // big endian pairs of the served bytes
			check_value("back_len", e[135:120], back_len);
			check_value("back_wid", e[119:104], back_wid);
			check_value("front_len", e[103:88], front_len);
			check_value("front_wid", e[87:72], front_wid);
			check_value("point_x", e[71:56], point_x);
			check_value("point_y", e[55:40], point_y);
			check_value("width", e[39:24], width);
			check_value("height", e[23:8], height);
			check_value("save", e[7:0], save);
			rec_seen++;
		end
	endtask

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (record_valid && valid_prev)
			begin
				$display("record_valid stayed high for more than one cycle at %0t ns", $time);
				n_errors++;
			end
			else if (record_valid)
				check_record();
			valid_prev = record_valid;
		end
	end

	// reset values, then the length of the chip reset pulse
	initial
	begin
		@(negedge clk);
		while (!rst_n)
		begin
			check_value("scs_n", 1'b1, scs_n);
			check_value("sck", 1'b0, sck);
			check_value("record_valid", 1'b0, record_valid);
			check_value("w5500_rst_n", 1'b1, w5500_rst_n);
			@(negedge clk);
		end
		while (w5500_rst_n !== 1'b0)
			@(negedge clk);
		low_cycles = 0;
		while (w5500_rst_n === 1'b0)
		begin
			low_cycles++;
			@(negedge clk);
		end
		check_value("w5500_rst_n low cycles", `RST_LOW_CYC, low_cycles);
	end

	initial
	begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Watchdog expired after %0d ns without all records arriving", limit_ns);
		n_errors++;
		finish_run();
	end

	initial
	begin
		load_trace();
		if (!trace_ok)
		begin
			$display("Could not read setup writes and records from %s", TRACE_PATH);
			n_errors++;
			finish_run();
		end
		else
		begin
			limit_ns = longint'(w_cnt + rsr_cnt + 4 * rec_cnt + 2) * FRAME_NS * 4;
			while (rec_seen < rec_cnt)
				@(negedge clk);
			frames_before = u_slave.frm_cnt;
			while (u_slave.frm_cnt < frames_before + 2)   // a few idle polls after
				@(negedge clk);
			verify_frames();
			finish_run();
		end
	end

endmodule

/* testbench/w5500_rx_trace.txt */
# W addr bsb len data: expected setup write, data left aligned in 6 bytes
# S value: served Sn_RX_RSR in poll order. R ptr bytes: Sn_RX_RD and 17 buffer bytes
W 0001 00 4 c0a864010000
W 0005 00 4 ffffff000000
W 0009 00 6 0c29ab7c0001
W 000f 00 4 c0a864100000
W 0000 08 1 010000000000
W 0004 08 2 138800000000
W 0001 08 1 010000000000
W 0001 08 1 020000000000
S 0000
S 0005
S 0011
S 0000
S 0028
R 0130 00c800640096005000100020014000f001
R fff8 1234abcd0f0f80017ffe5a5affff0000a5

/* build.f */
+incdir+rtl
rtl/w5500_pkg.sv
rtl/w5500_spi_if.sv
rtl/w5500_spi_master.sv
rtl/w5500_setup_seq.sv
rtl/w5500_rx_engine.sv
rtl/w5500_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/w5500_slave_model.sv
testbench/tb_w5500_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_w5500_top \
	-f build.f --Mdir obj_dir -o tb_w5500_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_w5500_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" sim.log; then
	exit 0
fi
exit 1
